// ==== main_bus_pkg.sv ====
package main_bus_pkg;

    typedef logic [23:1] cpu_addr_t;    // byte address with bit 0 dropped
    typedef logic [15:0] cpu_word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [18:0] prg_addr_t;    // program rom word address
    typedef logic [14:0] wram_addr_t;
    typedef logic [10:0] pal_addr_t;

    typedef enum logic [2:0] {
        TGT_NONE = 3'd0,
        TGT_ROM  = 3'd1,
        TGT_WRAM = 3'd2,
        TGT_PAL  = 3'd3,
        TGT_GCU  = 3'd4,
        TGT_IO   = 3'd5
    } bus_target_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_DECODE = 2'd1,
        ST_WAIT   = 2'd2,
        ST_ACK    = 2'd3
    } bus_state_t;

    // 96 MHz divided down to the cpu enables
    localparam int CEN_DIV     = 6;
    localparam int CEN_B_PHASE = 3;

    // memory map, compared against the byte address
    localparam logic [23:0] ROM_LAST    = 24'h07FFFF;
    localparam logic [7:0]  WRAM_PREFIX = 8'h10;       // 0x100000 - 0x10FFFF
    localparam logic [3:0]  GCU_PREFIX  = 4'h3;
    localparam logic [3:0]  PAL_PREFIX  = 4'h4;
    localparam logic [11:0] IO_PREFIX   = 12'h700;

    localparam int WRAM_AW = 15;
    localparam int PAL_AW  = 11;

    // cabinet i/o page offsets
    localparam logic [11:0] IO_JUMPER = 12'h000;
    localparam logic [11:0] IO_DSWA   = 12'h004;
    localparam logic [11:0] IO_DSWB   = 12'h008;
    localparam logic [11:0] IO_P1     = 12'h00C;
    localparam logic [11:0] IO_P2     = 12'h010;
    localparam logic [11:0] IO_SYS    = 12'h01C;

    // gcu register offsets
    localparam logic [3:0] GCU_PTR   = 4'h0;
    localparam logic [3:0] GCU_RAM_H = 4'h4;
    localparam logic [3:0] GCU_RAM_L = 4'h6;
    localparam logic [3:0] GCU_SEL   = 4'h8;
    localparam logic [3:0] GCU_REG   = 4'hC;

endpackage

// ==== bus_cycle_ctrl.sv ====
`timescale 1ns/1ns

module bus_cycle_ctrl import main_bus_pkg::*; (
    input  logic        clk96,
    input  logic        reset96,
    input  logic        as_n,
    input  logic        uds_n,
    input  logic        lds_n,
    input  logic        rw,
    input  cpu_addr_t   cpu_addr,
    input  logic        prg_ok,
    input  logic        gcu_done,
    output logic        cen16,
    output logic        cen16b,
    output logic        dtack_n,
    output bus_target_t target,
    output logic        data_load,
    output logic        prg_cs,
    output prg_addr_t   prg_addr,
    output logic        gcu_start,
    output logic [1:0]  wram_we,
    output logic [1:0]  pal_we
);

    logic [2:0]  cen_cnt;
    logic [23:0] byte_addr;
    bus_target_t decoded;
    bus_state_t  state;
    logic        first_wait;    // first ST_WAIT cycle
    logic        in_wait;
    logic        ready;
    logic        wr_pulse;
    logic [1:0]  lane_we;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            cen_cnt <= '0;
            cen16   <= 1'b0;
            cen16b  <= 1'b0;
        end else begin
            cen_cnt <= (cen_cnt == 3'(CEN_DIV - 1)) ? 3'd0 : cen_cnt + 3'd1;
            cen16   <= (cen_cnt == 3'(CEN_DIV - 1));     // high while count is 0
            cen16b  <= (cen_cnt == 3'(CEN_B_PHASE - 1));
        end
    end

    assign byte_addr = {cpu_addr, 1'b0};

    always_comb begin
        if (byte_addr <= ROM_LAST)
            decoded = TGT_ROM;
        else if (byte_addr[23:16] == WRAM_PREFIX)
            decoded = TGT_WRAM;
        else if (byte_addr[23:20] == GCU_PREFIX)
            decoded = TGT_GCU;
        else if (byte_addr[23:20] == PAL_PREFIX)
            decoded = TGT_PAL;
        else if (byte_addr[23:12] == IO_PREFIX)
            decoded = TGT_IO;
        else
            decoded = TGT_NONE;
    end

    assign in_wait  = (state == ST_WAIT);
    assign wr_pulse = in_wait && first_wait && !rw;
    assign lane_we  = {!uds_n, !lds_n};

    always_comb begin
        case (target)
            TGT_ROM:           ready = prg_ok;
            TGT_WRAM, TGT_PAL: ready = rw ? !first_wait : first_wait;  // reads wait for q
            TGT_GCU:           ready = gcu_done;
            default:           ready = first_wait;
        endcase
    end

    assign data_load = in_wait && ready;
    assign gcu_start = in_wait && first_wait && (target == TGT_GCU);
    assign prg_cs    = (target == TGT_ROM) && ((state == ST_DECODE) || in_wait);
    assign wram_we   = (wr_pulse && target == TGT_WRAM) ? lane_we : 2'b00;
    assign pal_we    = (wr_pulse && target == TGT_PAL) ? lane_we : 2'b00;

    always_ff @(posedge clk96) begin
        if (state == ST_IDLE && !as_n && decoded == TGT_ROM)
            prg_addr <= cpu_addr[19:1];
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state      <= ST_IDLE;
            target     <= TGT_NONE;
            first_wait <= 1'b0;
            dtack_n    <= 1'b1;
        end else begin
            first_wait <= (state == ST_DECODE);
            case (state)
                ST_IDLE: begin
                    if (!as_n) begin
                        target <= decoded;
                        state  <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (ready)
                        state <= ST_ACK;
                end
                ST_ACK: begin
                    if (dtack_n) begin
                        if (cen16)
                            dtack_n <= 1'b0;    // lines up with the cpu phase
                    end else if (as_n) begin
                        dtack_n <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== dual_port_ram16.sv ====
`timescale 1ns/1ns

module dual_port_ram16 import main_bus_pkg::*; #(
    parameter int aw = 11
) (
    input  logic          clk96,
    input  logic [aw-1:0] addr0,
    input  cpu_word_t     data0,
    input  logic [1:0]    we0,
    output cpu_word_t     q0,
    input  logic [aw-1:0] addr1,
    output cpu_word_t     q1
);

    byte_t mem_hi [2**aw];    // upper lane
    byte_t mem_lo [2**aw];    // lower lane

    // port 0, cpu side
    always_ff @(posedge clk96) begin
        if (we0[1])
            mem_hi[addr0] <= data0[15:8];
        if (we0[0])
            mem_lo[addr0] <= data0[7:0];
        q0 <= {mem_hi[addr0], mem_lo[addr0]};    // old data on a write
    end

    // port 1, read only
    always_ff @(posedge clk96) begin
        q1 <= {mem_hi[addr1], mem_lo[addr1]};
    end

endmodule

// ==== cabinet_inputs.sv ====
`timescale 1ns/1ns

module cabinet_inputs import main_bus_pkg::*; (
    input  logic [11:0] io_offset,
    input  logic [9:0]  joystick1,
    input  logic [9:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  byte_t       dipsw_a,
    input  byte_t       dipsw_b,
    input  byte_t       dipsw_c,
    output cpu_word_t   io_word
);

    byte_t p1_byte;
    byte_t p2_byte;
    byte_t sys_byte;

    // board inputs are active high, the frame gives them active low
    assign p1_byte = {1'b0, ~joystick1[6], ~joystick1[5], ~joystick1[4],
                      ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_byte = {1'b0, ~joystick2[6], ~joystick2[5], ~joystick2[4],
                      ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};

    assign sys_byte = {1'b0,
                       ~start_button[1],
                       ~start_button[0],
                       ~coin_input[1],
                       ~coin_input[0],
                       ~dip_test,
                       1'b0,
                       ~service};

    always_comb begin
        case (io_offset)
            IO_JUMPER: io_word = {2{dipsw_c}};
            IO_DSWA:   io_word = {2{dipsw_a}};
            IO_DSWB:   io_word = {2{dipsw_b}};
            IO_P1:     io_word = {2{p1_byte}};
            IO_P2:     io_word = {2{p2_byte}};
            IO_SYS:    io_word = {dipsw_c, sys_byte};    // region jumpers on top
            default:   io_word = 16'h0000;
        endcase
    end

endmodule

// ==== gcu_command.sv ====
`timescale 1ns/1ns

module gcu_command import main_bus_pkg::*; (
    input  logic       clk96,
    input  logic       reset96,
    input  logic       gcu_start,
    input  logic       rw,
    input  logic [3:0] gcu_offset,
    input  logic       gcu_ack,
    output logic       op_select_reg,
    output logic       op_write_reg,
    output logic       op_write_ram,
    output logic       op_read_ram_h,
    output logic       op_read_ram_l,
    output logic       op_set_ram_ptr,
    output logic       gcu_done
);

    logic op_hit;    // offset and direction name a real operation
    logic busy;

    always_comb begin
        if (rw)
            op_hit = (gcu_offset == GCU_RAM_H) || (gcu_offset == GCU_RAM_L);
        else
            op_hit = gcu_offset inside {GCU_PTR, GCU_RAM_H, GCU_RAM_L, GCU_SEL, GCU_REG};
    end

    assign busy = |{op_select_reg, op_write_reg, op_write_ram,
                    op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    // unknown offsets finish on the spot
    assign gcu_done = (gcu_start && !op_hit) || (busy && gcu_ack);

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            op_select_reg  <= 1'b0;
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
        end else if (gcu_start) begin
            op_read_ram_h  <= rw && (gcu_offset == GCU_RAM_H);
            op_read_ram_l  <= rw && (gcu_offset == GCU_RAM_L);
            op_write_reg   <= !rw && (gcu_offset == GCU_REG);
            op_select_reg  <= !rw && (gcu_offset == GCU_SEL);
            op_write_ram   <= !rw && (gcu_offset == GCU_RAM_H || gcu_offset == GCU_RAM_L);
            op_set_ram_ptr <= !rw && (gcu_offset == GCU_PTR);
        end else if (gcu_ack) begin
            op_select_reg  <= 1'b0;    // gcu took it
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
        end
    end

endmodule

// ==== cpu_read_mux.sv ====
`timescale 1ns/1ns

module cpu_read_mux import main_bus_pkg::*; (
    input  logic        clk96,
    input  logic        reset96,
    input  logic        data_load,
    input  bus_target_t target,
    input  logic        rw,
    input  cpu_word_t   prg_data,
    input  cpu_word_t   wram_q,
    input  cpu_word_t   pal_q,
    input  cpu_word_t   gcu_dout,
    input  cpu_word_t   io_word,
    output cpu_word_t   cpu_din
);

    cpu_word_t rd_word;

    always_comb begin
        case (target)
            TGT_ROM:  rd_word = prg_data;
            TGT_WRAM: rd_word = wram_q;
            TGT_PAL:  rd_word = pal_q;
            TGT_GCU:  rd_word = gcu_dout;
            TGT_IO:   rd_word = io_word;
            default:  rd_word = 16'h0000;    // open bus reads as zero
        endcase
    end

    // held between loads, the cpu latches it at dtack
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            cpu_din <= 16'h0000;
        end else if (data_load) begin
            cpu_din <= rw ? rd_word : 16'h0000;
        end
    end

endmodule

// ==== main_bus.sv ====
`timescale 1ns/1ns

module main_bus import main_bus_pkg::*; (
    input  logic       clk96,
    input  logic       reset96,
    // cpu bus
    input  logic       as_n,
    input  logic       uds_n,
    input  logic       lds_n,
    input  logic       rw,
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    output cpu_word_t  cpu_din,
    output logic       dtack_n,
    output logic       cen16,
    output logic       cen16b,
    // program rom
    output logic       prg_cs,
    output prg_addr_t  prg_addr,
    input  logic       prg_ok,
    input  cpu_word_t  prg_data,
    // gcu
    output logic       op_select_reg,
    output logic       op_write_reg,
    output logic       op_write_ram,
    output logic       op_read_ram_h,
    output logic       op_read_ram_l,
    output logic       op_set_ram_ptr,
    input  logic       gcu_ack,
    input  cpu_word_t  gcu_dout,
    // cabinet
    input  logic [9:0] joystick1,
    input  logic [9:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    input  byte_t      dipsw_c,
    // palette video port
    input  pal_addr_t  pal_video_addr,
    output cpu_word_t  pal_video_data
);

    bus_target_t target;
    logic        data_load;
    logic        gcu_start;
    logic        gcu_done;
    logic [1:0]  wram_we;
    logic [1:0]  pal_we;
    cpu_word_t   wram_q;
    cpu_word_t   pal_q;
    cpu_word_t   io_word;
    wram_addr_t  wram_addr;
    pal_addr_t   pal_cpu_addr;
    logic [11:0] io_offset;
    logic [3:0]  gcu_offset;

    assign wram_addr    = cpu_addr[15:1];
    assign pal_cpu_addr = cpu_addr[11:1];
    assign io_offset    = {cpu_addr[11:1], 1'b0};    // byte offset in the i/o page
    assign gcu_offset   = {cpu_addr[3:1], 1'b0};

    bus_cycle_ctrl u_ctrl (
        .clk96     (clk96),
        .reset96   (reset96),
        .as_n      (as_n),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .rw        (rw),
        .cpu_addr  (cpu_addr),
        .prg_ok    (prg_ok),
        .gcu_done  (gcu_done),
        .cen16     (cen16),
        .cen16b    (cen16b),
        .dtack_n   (dtack_n),
        .target    (target),
        .data_load (data_load),
        .prg_cs    (prg_cs),
        .prg_addr  (prg_addr),
        .gcu_start (gcu_start),
        .wram_we   (wram_we),
        .pal_we    (pal_we)
    );

    // work ram 0x100000-0x10FFFF, cpu reads through port 1
    dual_port_ram16 #(.aw(WRAM_AW)) u_wram (
        .clk96 (clk96),
        .addr0 (wram_addr),
        .data0 (cpu_dout),
        .we0   (wram_we),
        .q0    (),
        .addr1 (wram_addr),
        .q1    (wram_q)
    );

    dual_port_ram16 #(.aw(PAL_AW)) u_palram (
        .clk96 (clk96),
        .addr0 (pal_cpu_addr),
        .data0 (cpu_dout),
        .we0   (pal_we),
        .q0    (pal_q),
        .addr1 (pal_video_addr),
        .q1    (pal_video_data)
    );

    cabinet_inputs u_inputs (
        .io_offset    (io_offset),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .io_word      (io_word)
    );

    gcu_command u_gcu_cmd (
        .clk96          (clk96),
        .reset96        (reset96),
        .gcu_start      (gcu_start),
        .rw             (rw),
        .gcu_offset     (gcu_offset),
        .gcu_ack        (gcu_ack),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .op_set_ram_ptr (op_set_ram_ptr),
        .gcu_done       (gcu_done)
    );

    cpu_read_mux u_rd_mux (
        .clk96     (clk96),
        .reset96   (reset96),
        .data_load (data_load),
        .target    (target),
        .rw        (rw),
        .prg_data  (prg_data),
        .wram_q    (wram_q),
        .pal_q     (pal_q),
        .gcu_dout  (gcu_dout),
        .io_word   (io_word),
        .cpu_din   (cpu_din)
    );

endmodule

// ==== main_bus_assertions.sv ====
`timescale 1ns/1ns

module main_bus_assertions (
    input logic       clk96,
    input logic       reset96,
    input logic       as_n,
    input logic       dtack_n,
    input logic       cen16,
    input logic       cen16b,
    input logic       prg_cs,
    input logic [5:0] ops
);

    // dtack may lag as_n by the one release cycle
    a_dtack_needs_as: assert property (@(posedge clk96) disable iff (reset96)
        (!dtack_n && as_n) |-> $past(!as_n)) else $error("dtack_n low without as_n");

    a_one_op: assert property (@(posedge clk96) disable iff (reset96)
        $onehot0(ops)) else $error("more than one gcu op level high");

    a_cen_apart: assert property (@(posedge clk96) disable iff (reset96)
        !(cen16 && cen16b)) else $error("cen16 and cen16b overlap");

    a_prg_cs_in_cycle: assert property (@(posedge clk96) disable iff (reset96)
        prg_cs |-> !as_n) else $error("prg_cs outside a bus cycle");

endmodule

bind bus_cycle_ctrl main_bus_assertions u_ctrl_sva (
    .clk96 (clk96), .reset96 (reset96), .as_n (as_n), .dtack_n (dtack_n),
    .cen16 (cen16), .cen16b (cen16b), .prg_cs (prg_cs), .ops (6'b000000)
);

bind gcu_command main_bus_assertions u_gcu_sva (
    .clk96 (clk96), .reset96 (reset96), .as_n (1'b1), .dtack_n (1'b1),
    .cen16 (1'b0), .cen16b (1'b0), .prg_cs (1'b0),
    .ops ({op_select_reg, op_write_reg, op_write_ram,
           op_read_ram_h, op_read_ram_l, op_set_ram_ptr})
);

// ==== bus_checker.sv ====
`timescale 1ns/1ns

module bus_checker import main_bus_pkg::*; (
    input  logic       clk96,
    input  logic       reset96,
    input  logic       as_n,
    input  logic       uds_n,
    input  logic       lds_n,
    input  logic       rw,
    input  cpu_addr_t  cpu_addr,
    input  cpu_word_t  cpu_dout,
    input  cpu_word_t  cpu_din,
    input  logic       dtack_n,
    input  logic       cen16,
    input  logic       cen16b,
    input  logic       prg_cs,
    input  prg_addr_t  prg_addr,
    input  logic       prg_ok,
    input  logic [5:0] ops,          // sel, wreg, wram, read h, read l, ptr
    input  logic       gcu_ack,
    input  cpu_word_t  gcu_dout,
    input  logic [9:0] joystick1,
    input  logic [9:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    input  byte_t      dipsw_c,
    input  pal_addr_t  pal_video_addr,
    input  cpu_word_t  pal_video_data
);

    int         error_count = 0;
    int         access_count = 0;
    cpu_word_t  wram_m [int];
    cpu_word_t  pal_m [int];
    logic       prev_dtack_n;
    logic       prev_as_n;
    logic       prev_ack;
    logic [5:0] prev_ops;
    logic [5:0] ops_seen;
    pal_addr_t  prev_vaddr;
    logic       ok_seen;
    logic       ack_seen;
    int         gap_a;
    int         gap_b;

    function automatic bus_target_t map_decode(input logic [23:0] a);
        if (a <= 24'h07FFFF) return TGT_ROM;
        if (a[23:16] == 8'h10) return TGT_WRAM;
        if (a[23:20] == 4'h3) return TGT_GCU;
        if (a[23:20] == 4'h4) return TGT_PAL;
        if (a[23:12] == 12'h700) return TGT_IO;
        return TGT_NONE;
    endfunction

    function automatic byte_t player_byte(input logic [9:0] j);
        return {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    function automatic cpu_word_t io_expect(input logic [11:0] off);
        case (off)
            12'h000: return {dipsw_c, dipsw_c};
            12'h004: return {dipsw_a, dipsw_a};
            12'h008: return {dipsw_b, dipsw_b};
            12'h00C: return {player_byte(joystick1), player_byte(joystick1)};
            12'h010: return {player_byte(joystick2), player_byte(joystick2)};
            12'h01C: return {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                             ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service};
            default: return 16'h0000;
        endcase
    endfunction

    // expected op level for a gcu offset and direction
    function automatic logic [5:0] op_expect(input logic [3:0] off, input logic rd);
        if (rd) return (off == 4'h4) ? 6'b000100 : (off == 4'h6) ? 6'b000010 : 6'b000000;
        case (off)
            4'h0: return 6'b000001;
            4'h4, 4'h6: return 6'b001000;
            4'h8: return 6'b100000;
            4'hC: return 6'b010000;
            default: return 6'b000000;
        endcase
    endfunction

    task automatic value_error(input string name, input cpu_word_t got, input cpu_word_t exp);
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic plain_error(input string what);
        $display("[ERROR] %0t %s", $time, what);
        error_count++;
    endtask

    task automatic report_counts();
        $display("checker: %0d accesses checked, %0d errors", access_count, error_count);
    endtask

    always @(posedge clk96) begin : watch
        bus_target_t tgt;
        cpu_word_t   exp_word;
        cpu_word_t   cur;
        logic [5:0]  exp_ops;
        int          key;
        if (reset96) begin
            prev_dtack_n = 1'b1;
            prev_as_n    = 1'b1;
            prev_ack     = 1'b0;
            prev_ops     = '0;
            ops_seen     = '0;
            ok_seen      = 1'b0;
            ack_seen     = 1'b0;
            gap_a        = -1;
            gap_b        = -1;
        end else begin
            tgt = map_decode({cpu_addr, 1'b0});
            if (cen16 && cen16b)
                plain_error("cen16 and cen16b high in the same cycle");
            if (gap_a >= 0) gap_a++;
            if (gap_b >= 0) gap_b++;
            if (cen16) begin
                if (gap_a >= 0 && gap_a != CEN_DIV)
                    plain_error("cen16 period is not 6 cycles");
                gap_a = 0;
            end
            if (cen16b) begin
                if (gap_b >= 0 && gap_b != CEN_DIV)
                    plain_error("cen16b period is not 6 cycles");
                gap_b = 0;
            end
            if (prg_cs && as_n)
                plain_error("prg_cs high with no bus cycle");
            if (prg_cs && prg_addr != cpu_addr[19:1])
                value_error("prg_addr", 16'(prg_addr), 16'(cpu_addr[19:1]));
            if (prg_cs && prg_ok)
                ok_seen = 1'b1;
            if (as_n && prev_as_n && ops != 0)
                plain_error("gcu op level high outside a gcu access");
            if ((prev_ops & ~ops) != 0 && !prev_ack)
                plain_error("gcu op level dropped before gcu_ack");
            if (ops != 0 && gcu_ack)
                ack_seen = 1'b1;
            ops_seen |= ops;
            // palette video port, only while the cpu side is quiet
            key = int'(prev_vaddr);
            if (as_n && prev_as_n && pal_m.exists(key) && pal_video_data !== pal_m[key])
                value_error("pal_video_data", pal_video_data, pal_m[key]);

            if (!dtack_n && prev_dtack_n) begin
                if (as_n) begin
                    plain_error("dtack_n fell while as_n was high");
                end else if (rw) begin
                    case (tgt)
                        TGT_ROM: begin
                            exp_word = cpu_addr[16:1] ^ 16'hA5A5;
                            if (!ok_seen)
                                plain_error("rom cycle acknowledged before prg_ok");
                        end
                        TGT_WRAM: exp_word = wram_m[int'(cpu_addr[15:1])];
                        TGT_PAL:  exp_word = pal_m[int'(cpu_addr[11:1])];
                        TGT_GCU:  exp_word = gcu_dout;
                        TGT_IO:   exp_word = io_expect({cpu_addr[11:1], 1'b0});
                        default:  exp_word = 16'h0000;
                    endcase
                    if (cpu_din !== exp_word)
                        value_error("cpu_din", cpu_din, exp_word);
                end else if (tgt == TGT_WRAM || tgt == TGT_PAL) begin
                    key = (tgt == TGT_WRAM) ? int'(cpu_addr[15:1]) : int'(cpu_addr[11:1]);
                    if (tgt == TGT_WRAM)
                        cur = wram_m.exists(key) ? wram_m[key] : 16'hxxxx;
                    else
                        cur = pal_m.exists(key) ? pal_m[key] : 16'hxxxx;
                    if (!uds_n) cur[15:8] = cpu_dout[15:8];
                    if (!lds_n) cur[7:0] = cpu_dout[7:0];
                    if (tgt == TGT_WRAM) wram_m[key] = cur;
                    else pal_m[key] = cur;
                end
                if (!as_n && tgt == TGT_GCU) begin
                    exp_ops = op_expect({cpu_addr[3:1], 1'b0}, rw);
                    if (ops_seen != exp_ops)
                        value_error("gcu op levels", 16'(ops_seen), 16'(exp_ops));
                    if (exp_ops != 0 && !ack_seen)
                        plain_error("gcu cycle acknowledged before gcu_ack");
                end
                ops_seen = '0;
                ok_seen  = 1'b0;
                ack_seen = 1'b0;
                access_count++;
            end
            prev_dtack_n = dtack_n;
            prev_as_n    = as_n;
            prev_ack     = gcu_ack;
            prev_ops     = ops;
            prev_vaddr   = pal_video_addr;
        end
    end

endmodule

// ==== tb_main_bus.sv ====
`timescale 1ns/1ns

module tb_main_bus import main_bus_pkg::*; ();

    localparam int N_ACCESS   = 400;
    localparam int MAX_CYCLES = 20000;    // 400 accesses at ~30 cycles plus margin

    logic clk96, reset96, as_n, uds_n, lds_n, rw;
    cpu_addr_t cpu_addr;
    cpu_word_t cpu_dout, cpu_din, prg_data, gcu_dout, pal_video_data;
    logic dtack_n, cen16, cen16b, prg_cs, prg_ok, gcu_ack;
    prg_addr_t prg_addr;
    logic op_select_reg, op_write_reg, op_write_ram;
    logic op_read_ram_h, op_read_ram_l, op_set_ram_ptr;
    logic [9:0] joystick1, joystick2;
    logic [1:0] start_button, coin_input;
    logic service, dip_test;
    byte_t dipsw_a, dipsw_b, dipsw_c;
    pal_addr_t pal_video_addr;
    logic [5:0] ops;

    int seed = 32'h0b3e_43b0;
    int rom_delay = 0;
    int gcu_delay = 0;
    int cycle_count = 0;

    assign ops = {op_select_reg, op_write_reg, op_write_ram,
                  op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    main_bus uut (.*);
    bus_checker u_checker (.*);

    always #2 clk96 = ~clk96;

    always @(posedge clk96) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
            u_checker.report_counts();
            $display("test failed");
            $finish;
        end
    end

    // program rom answers after the chosen delay
    initial begin
        forever begin
            @(posedge clk96);
            #1;
            if (prg_cs) begin
                repeat (rom_delay) @(posedge clk96);
                #1 prg_data = prg_addr[15:0] ^ 16'hA5A5;
                prg_ok = 1'b1;
                @(posedge clk96);
                #1 prg_ok = 1'b0;
            end
        end
    end

    // gcu acks any raised op level
    initial begin
        forever begin
            @(posedge clk96);
            #1;
            if (ops != 0) begin
                repeat (gcu_delay) @(posedge clk96);
                #1 gcu_ack = 1'b1;
                @(posedge clk96);
                #1 gcu_ack = 1'b0;
            end
        end
    end

    function automatic logic [23:0] wram_byte(input int k);
        return 24'h100000 + 24'((k * 7 + 3) * 2);
    endfunction

    function automatic logic [23:0] pal_byte(input int k);
        return 24'h400000 + 24'((k * 3 + 1) * 2);
    endfunction

    function automatic logic [11:0] io_pick(input int i);
        case (i)
            0: return IO_JUMPER;
            1: return IO_DSWA;
            2: return IO_DSWB;
            3: return IO_P1;
            4: return IO_P2;
            5: return IO_SYS;
            default: return 12'h020;    // nothing there
        endcase
    endfunction

    task automatic bus_access(input logic [23:0] ba, input logic wr, input logic [1:0] lanes,
                              input cpu_word_t data);
        @(posedge clk96);
        #1 cpu_addr = ba[23:1];
        rw = !wr;
        uds_n = !lanes[1];
        lds_n = !lanes[0];
        cpu_dout = data;
        as_n = 1'b0;
        do @(posedge clk96); while (dtack_n);
        #1 as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        do @(posedge clk96); while (!dtack_n);
        #1;
    endtask

    task automatic idle_gap();
        int r;
        int n;
        logic [23:0] video_ba;
        r = $random(seed);
        n = 1 + (r & 3);
        joystick1 = r[13:4];
        joystick2 = r[23:14];
        start_button = r[25:24];
        coin_input = r[27:26];
        service = r[28];
        dip_test = r[29];
        r = $random(seed);
        dipsw_a = r[7:0];
        dipsw_b = r[15:8];
        dipsw_c = r[23:16];
        repeat (n) begin
            @(posedge clk96);
            #1 video_ba = pal_byte($unsigned($random(seed)) % 16);
            pal_video_addr = video_ba[11:1];
        end
    endtask

    task automatic random_access();
        int r;
        int kind;
        logic [23:0] ba;
        logic wr;
        logic [1:0] lanes;
        kind = $unsigned($random(seed)) % 6;
        r = $random(seed);
        rom_delay = $unsigned($random(seed)) % 8;
        gcu_delay = $unsigned($random(seed)) % 8;
        gcu_dout = r[31:16];
        wr = r[0] && (kind inside {1, 2, 3});
        lanes = wr ? 2'(1 + ($unsigned($random(seed)) % 3)) : 2'b11;
        case (kind)
            0: ba = {5'b0, r[18:1], 1'b0};
            1: ba = wram_byte(r[7:4]);
            2: ba = pal_byte(r[7:4]);
            3: ba = 24'h300000 | {20'h0, r[3:1], 1'b0};
            4: ba = {12'h700, io_pick($unsigned(r) % 7)};
            default: ba = r[1] ? {8'h20, r[15:1], 1'b0} : {4'h9, r[19:1], 1'b0};
        endcase
        bus_access(ba, wr, lanes, 16'($random(seed)));
    endtask

    initial begin
        clk96 = 1'b0;
        reset96 = 1'b1;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rw = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        prg_ok = 1'b0;
        prg_data = '0;
        gcu_ack = 1'b0;
        gcu_dout = '0;
        joystick1 = '0;
        joystick2 = '0;
        start_button = '0;
        coin_input = '0;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        pal_video_addr = '0;
        repeat (16) @(posedge clk96);
        #1 reset96 = 1'b0;
        repeat (24) @(posedge clk96);    // quiet bus while the enables run alone
        for (int k = 0; k < 16; k++) begin
            bus_access(wram_byte(k), 1'b1, 2'b11, 16'($random(seed)));
            bus_access(pal_byte(k), 1'b1, 2'b11, 16'($random(seed)));
        end
        for (int n = 0; n < N_ACCESS; n++) begin
            random_access();
            idle_gap();
        end
        repeat (4) @(posedge clk96);
        u_checker.report_counts();
        if (u_checker.error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
main_bus_pkg.sv
bus_cycle_ctrl.sv
dual_port_ram16.sv
cabinet_inputs.sv
gcu_command.sv
cpu_read_mux.sv
main_bus.sv
main_bus_assertions.sv
bus_checker.sv
tb_main_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_main_bus -f src.f -o sim_main_bus
./obj_dir/sim_main_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation ok"
